// File: common/bw_mul_pkg.sv
`default_nettype none

package bw_mul_pkg;

	////////////////////////////////////////////////////////////////////////////
	// default sizes for the top level
	////////////////////////////////////////////////////////////////////////////

	// operand width in bits
	localparam int DEFAULT_DATA_W = 16;

	// array rows per registered stage, data width must be a multiple
	localparam int DEFAULT_ROWS_PER_STAGE = 4;

	////////////////////////////////////////////////////////////////////////////
	// baugh-wooley cell kinds
	////////////////////////////////////////////////////////////////////////////

	// white adds a_i & b_j, gray adds its complement
	typedef enum logic [0:0] {
		CELL_WHITE = 1'b0,
		CELL_GRAY  = 1'b1
	} cell_kind_e;

	// gray when exactly one of column and row is the sign index
	function automatic cell_kind_e bw_cell_kind(input int col, input int row, input int width);
		if ((col == width - 1) != (row == width - 1)) begin
			return CELL_GRAY;
		end
		return CELL_WHITE;
	endfunction

endpackage

`default_nettype wire

// File: bw_array/bw_pp_row.sv
`timescale 1ns/10ps
`default_nettype none

module bw_pp_row #(
	parameter int DATA_W = bw_mul_pkg::DEFAULT_DATA_W,
	parameter int ROW    = 0
) (
	input  wire logic [DATA_W-1:0]   a,
	input  wire logic [DATA_W-1:0]   b,
	input  wire logic [2*DATA_W-1:0] sum_in,
	input  wire logic [2*DATA_W-1:0] carry_in,
	output logic      [2*DATA_W-1:0] sum_out,
	output logic      [2*DATA_W-1:0] carry_out
);

	// partial product bits of this row, before placing at weight 2^ROW
	logic [DATA_W-1:0]   pp_bit;
	// partial product aligned into the full product width
	logic [2*DATA_W-1:0] pp_row;
	// incoming carries move up one column
	logic [2*DATA_W-1:0] carry_sh;

	////////////////////////////////////////////////////////////////////////////
	// and gates, complemented in the gray cells
	////////////////////////////////////////////////////////////////////////////

	genvar col;
	generate
		for (col = 0; col < DATA_W; col++) begin : g_cell
			localparam bw_mul_pkg::cell_kind_e KIND = bw_mul_pkg::bw_cell_kind(col, ROW, DATA_W);

			if (KIND == bw_mul_pkg::CELL_GRAY) begin : g_gray
				assign pp_bit[col] = ~(a[col] & b[ROW]);
			end else begin : g_white
				assign pp_bit[col] = a[col] & b[ROW];
			end
		end
	endgenerate

	assign pp_row   = {{DATA_W{1'b0}}, pp_bit} << ROW;
	assign carry_sh = {carry_in[2*DATA_W-2:0], 1'b0};

	////////////////////////////////////////////////////////////////////////////
	// one full adder per column, 3:2 compression
	////////////////////////////////////////////////////////////////////////////

	// carry_out keeps its own column index, the next row shifts it
	assign sum_out   = pp_row ^ sum_in ^ carry_sh;
	assign carry_out = (pp_row & sum_in) | (pp_row & carry_sh) | (sum_in & carry_sh);

endmodule

`default_nettype wire

// File: bw_array/bw_array_stage.sv
`timescale 1ns/10ps
`default_nettype none

module bw_array_stage #(
	parameter int DATA_W         = bw_mul_pkg::DEFAULT_DATA_W,
	parameter int ROWS_PER_STAGE = bw_mul_pkg::DEFAULT_ROWS_PER_STAGE,
	parameter int FIRST_ROW      = 0
) (
	input  wire logic                clk,
	input  wire logic                rst,

	input  wire logic                up_valid,
	output logic                     up_ready,
	input  wire logic [DATA_W-1:0]   up_a,
	input  wire logic [DATA_W-1:0]   up_b,
	input  wire logic [2*DATA_W-1:0] up_sum,
	input  wire logic [2*DATA_W-1:0] up_carry,

	output logic                     dn_valid,
	input  wire logic                dn_ready,
	output logic      [DATA_W-1:0]   dn_a,
	output logic      [DATA_W-1:0]   dn_b,
	output logic      [2*DATA_W-1:0] dn_sum,
	output logic      [2*DATA_W-1:0] dn_carry
);

	// carry-save vectors between rows, entry 0 is the stage input
	logic [ROWS_PER_STAGE:0][2*DATA_W-1:0] row_sum;
	logic [ROWS_PER_STAGE:0][2*DATA_W-1:0] row_carry;

	logic load;

	assign row_sum[0]   = up_sum;
	assign row_carry[0] = up_carry;

	////////////////////////////////////////////////////////////////////////////
	// rows FIRST_ROW .. FIRST_ROW+ROWS_PER_STAGE-1, no registers in between
	////////////////////////////////////////////////////////////////////////////

	genvar r;
	generate
		for (r = 0; r < ROWS_PER_STAGE; r++) begin : g_row
			bw_pp_row #(
				.DATA_W (DATA_W),
				.ROW    (FIRST_ROW + r)
			) u_row (
				.a         (up_a),
				.b         (up_b),
				.sum_in    (row_sum[r]),
				.carry_in  (row_carry[r]),
				.sum_out   (row_sum[r+1]),
				.carry_out (row_carry[r+1])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// single pipeline slot
	////////////////////////////////////////////////////////////////////////////

	// free when empty or when the slot drains this cycle
	assign up_ready = ~dn_valid | dn_ready;
	assign load     = up_valid & up_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			dn_valid <= 1'b0;
		end else if (up_ready) begin
			dn_valid <= up_valid;
		end
	end

	// operands travel along, later rows still need them
	always_ff @(posedge clk) begin
		if (load) begin
			dn_a     <= up_a;
			dn_b     <= up_b;
			dn_sum   <= row_sum[ROWS_PER_STAGE];
			dn_carry <= row_carry[ROWS_PER_STAGE];
		end
	end

endmodule

`default_nettype wire

// File: design/bw_final_adder.sv
`timescale 1ns/10ps
`default_nettype none

module bw_final_adder #(
	parameter int DATA_W = bw_mul_pkg::DEFAULT_DATA_W
) (
	input  wire logic                       clk,
	input  wire logic                       rst,

	input  wire logic                       up_valid,
	output logic                            up_ready,
	input  wire logic        [2*DATA_W-1:0] up_sum,
	input  wire logic        [2*DATA_W-1:0] up_carry,

	output logic                            dn_valid,
	input  wire logic                       dn_ready,
	output logic signed      [2*DATA_W-1:0] dn_product
);

	////////////////////////////////////////////////////////////////////////////
	// carry-propagate merge
	////////////////////////////////////////////////////////////////////////////

	// baugh-wooley correction ones at bit DATA_W and at the top bit
	localparam logic [2*DATA_W-1:0] CORRECTION =
		(2*DATA_W)'(1) << DATA_W | (2*DATA_W)'(1) << (2*DATA_W - 1);

	logic [2*DATA_W-1:0] carry_sh;
	logic [2*DATA_W-1:0] merged;
	logic                load;

	// top carry bit falls off, the result is modulo 2^(2*DATA_W)
	assign carry_sh = {up_carry[2*DATA_W-2:0], 1'b0};
	assign merged   = up_sum + carry_sh + CORRECTION;

	////////////////////////////////////////////////////////////////////////////
	// output slot
	////////////////////////////////////////////////////////////////////////////

	assign up_ready = ~dn_valid | dn_ready;
	assign load     = up_valid & up_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			dn_valid <= 1'b0;
		end else if (up_ready) begin
			dn_valid <= up_valid;
		end
	end

	// product holds while the consumer stalls
	always_ff @(posedge clk) begin
		if (load) begin
			dn_product <= merged;
		end
	end

endmodule

`default_nettype wire

// File: design/bw_mul_top.sv
`timescale 1ns/10ps
`default_nettype none

module bw_mul_top #(
	parameter int DATA_W         = bw_mul_pkg::DEFAULT_DATA_W,
	parameter int ROWS_PER_STAGE = bw_mul_pkg::DEFAULT_ROWS_PER_STAGE
) (
	input  wire logic                       clk,
	input  wire logic                       rst,

	input  wire logic                       in_valid,
	output logic                            in_ready,
	input  wire logic signed [DATA_W-1:0]   in_a,
	input  wire logic signed [DATA_W-1:0]   in_b,

	output logic                            out_valid,
	input  wire logic                       out_ready,
	output logic signed      [2*DATA_W-1:0] out_product
);

	// DATA_W must divide evenly into stages
	localparam int NUM_STAGES = DATA_W / ROWS_PER_STAGE;

	// index 0 is the input port side, index NUM_STAGES feeds the final adder
	logic [NUM_STAGES:0]                 st_valid;
	logic [NUM_STAGES:0]                 st_ready;
	logic [NUM_STAGES:0][DATA_W-1:0]     st_a;
	logic [NUM_STAGES:0][DATA_W-1:0]     st_b;
	logic [NUM_STAGES:0][2*DATA_W-1:0]   st_sum;
	logic [NUM_STAGES:0][2*DATA_W-1:0]   st_carry;

	// the array starts from an empty carry-save pair
	assign st_valid[0] = in_valid;
	assign in_ready    = st_ready[0];
	assign st_a[0]     = in_a;
	assign st_b[0]     = in_b;
	assign st_sum[0]   = '0;
	assign st_carry[0] = '0;

	genvar s;
	generate
		for (s = 0; s < NUM_STAGES; s++) begin : g_stage
			bw_array_stage #(
				.DATA_W         (DATA_W),
				.ROWS_PER_STAGE (ROWS_PER_STAGE),
				.FIRST_ROW      (s * ROWS_PER_STAGE)
			) u_stage (
				.clk      (clk),
				.rst      (rst),
				.up_valid (st_valid[s]),
				.up_ready (st_ready[s]),
				.up_a     (st_a[s]),
				.up_b     (st_b[s]),
				.up_sum   (st_sum[s]),
				.up_carry (st_carry[s]),
				.dn_valid (st_valid[s+1]),
				.dn_ready (st_ready[s+1]),
				.dn_a     (st_a[s+1]),
				.dn_b     (st_b[s+1]),
				.dn_sum   (st_sum[s+1]),
				.dn_carry (st_carry[s+1])
			);
		end
	endgenerate

	bw_final_adder #(
		.DATA_W (DATA_W)
	) u_final (
		.clk        (clk),
		.rst        (rst),
		.up_valid   (st_valid[NUM_STAGES]),
		.up_ready   (st_ready[NUM_STAGES]),
		.up_sum     (st_sum[NUM_STAGES]),
		.up_carry   (st_carry[NUM_STAGES]),
		.dn_valid   (out_valid),
		.dn_ready   (out_ready),
		.dn_product (out_product)
	);

endmodule

`default_nettype wire

// File: bench/bw_mul_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bw_mul_tb;

	localparam int DATA_W     = bw_mul_pkg::DEFAULT_DATA_W;
	// one cycle per array stage plus the final adder
	localparam int LATENCY    = DATA_W / bw_mul_pkg::DEFAULT_ROWS_PER_STAGE + 1;
	localparam int N_BURST    = 50;
	localparam int N_CORNER   = 8;
	localparam int N_RANDOM   = 2000;
	localparam int N_BP       = 200;
	localparam int N_TOTAL    = N_BURST + N_CORNER + N_RANDOM + N_BP;
	// up to 8 cycles per pair with gaps and stalls, plus reset and drain
	localparam int MAX_CYCLES = 8 * N_TOTAL + 2000;
	// cycles allowed for the pipeline to empty after the last input
	localparam int DRAIN_LIMIT = 20 * LATENCY;

	localparam logic signed [DATA_W-1:0] MOST_NEG  = {1'b1, {(DATA_W-1){1'b0}}};
	localparam logic signed [DATA_W-1:0] MOST_POS  = {1'b0, {(DATA_W-1){1'b1}}};
	localparam logic signed [DATA_W-1:0] MINUS_ONE = {DATA_W{1'b1}};
	localparam logic signed [DATA_W-1:0] PLUS_ONE  = {{(DATA_W-1){1'b0}}, 1'b1};
	localparam logic signed [DATA_W-1:0] ZERO      = '0;

	logic                       clk;
	logic                       rst;
	logic                       in_valid;
	logic                       in_ready;
	logic signed [DATA_W-1:0]   in_a;
	logic signed [DATA_W-1:0]   in_b;
	logic                       out_valid;
	logic                       out_ready;
	logic signed [2*DATA_W-1:0] out_product;

	integer                     seed;
	logic [31:0]                rnd;
	string                      test_name;
	logic                       bp_mode;
	logic                       lat_check;
	int                         value_errors;
	int                         other_errors;
	int                         cycle_count;
	int                         elapsed;
	int                         in_count;
	logic                       hold_pending;
	logic signed [2*DATA_W-1:0] held_product;
	logic signed [2*DATA_W-1:0] exp_q[$];
	int                         acc_q[$];
	logic signed [2*DATA_W-1:0] exp_prod;
	int                         acc_cycle;
	logic signed [DATA_W-1:0]   op_a;
	logic signed [DATA_W-1:0]   op_b;

	bw_mul_top #(
		.DATA_W         (DATA_W),
		.ROWS_PER_STAGE (bw_mul_pkg::DEFAULT_ROWS_PER_STAGE)
	) u_dut (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_a        (in_a),
		.in_b        (in_b),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_product (out_product)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// plain signed arithmetic on sign-extended operands
	function automatic logic signed [2*DATA_W-1:0] model_product(
			input logic signed [DATA_W-1:0] a, input logic signed [DATA_W-1:0] b);
		logic signed [2*DATA_W-1:0] ax;
		logic signed [2*DATA_W-1:0] bx;
		ax = {{DATA_W{a[DATA_W-1]}}, a};
		bx = {{DATA_W{b[DATA_W-1]}}, b};
		return ax * bx;
	endfunction

	task automatic check_product(input string name, input logic signed [2*DATA_W-1:0] expected,
			input logic signed [2*DATA_W-1:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			value_errors++;
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers stepping on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(negedge clk);
		if (bp_mode) begin
			rnd = $random(seed);
			out_ready = rnd[0];
		end
	endtask

	task automatic random_operand(output logic signed [DATA_W-1:0] value);
		rnd = $random(seed);
		value = rnd[DATA_W-1:0];
	endtask

	// idle for gap cycles, then hold the pair until the monitor sees it accepted
	task automatic send_pair(input logic signed [DATA_W-1:0] a,
			input logic signed [DATA_W-1:0] b, input int gap);
		int start;
		in_valid = 1'b0;
		repeat (gap) next_cycle();
		start = in_count;
		in_valid = 1'b1;
		in_a = a;
		in_b = b;
		while (in_count == start) begin
			next_cycle();
		end
	endtask

	task automatic send_random(input int count, input logic random_gap);
		int gap;
		for (int i = 0; i < count; i++) begin
			random_operand(op_a);
			random_operand(op_b);
			rnd = $random(seed);
			gap = random_gap ? {30'b0, rnd[1:0]} : 0;
			send_pair(op_a, op_b, gap);
		end
		in_valid = 1'b0;
	endtask

	// gives up after a bounded wait so lost products show up as leftovers
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited++;
		end
		repeat (2) next_cycle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitor and scoreboard
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count++;
		if (!rst) begin
			// a stalled product must stay put
			if (hold_pending) begin
				check_flag({test_name, " hold valid"}, 1'b1, out_valid);
				check_product({test_name, " hold product"}, held_product, out_product);
			end
			hold_pending = out_valid & ~out_ready;
			held_product = out_product;
			if (lat_check && in_valid) begin
				check_flag({test_name, " in_ready"}, 1'b1, in_ready);
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(model_product(in_a, in_b));
				acc_q.push_back(cycle_count);
				in_count++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("%s: a product came out with nothing expected", test_name);
				end else begin
					exp_prod = exp_q.pop_front();
					acc_cycle = acc_q.pop_front();
					check_product(test_name, exp_prod, out_product);
					if (lat_check) begin
						check_latency({test_name, " latency"}, LATENCY, cycle_count - acc_cycle);
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		elapsed++;
		if (elapsed >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing the tests", elapsed);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'hb3a0_ac71;
		rnd = '0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_a = '0;
		in_b = '0;
		out_ready = 1'b1;
		bp_mode = 1'b0;
		lat_check = 1'b0;
		value_errors = 0;
		other_errors = 0;
		cycle_count = 0;
		elapsed = 0;
		in_count = 0;
		hold_pending = 1'b0;
		held_product = '0;
		op_a = '0;
		op_b = '0;
		test_name = "reset";
		repeat (2) @(negedge clk);
		rst = 1'b0;
		check_flag("reset out_valid", 1'b0, out_valid);
		check_flag("reset in_ready", 1'b1, in_ready);
		next_cycle();
		check_flag("idle out_valid", 1'b0, out_valid);

		test_name = "burst";
		lat_check = 1'b1;
		send_random(N_BURST, 1'b0);
		drain();
		lat_check = 1'b0;

		// every gray cell and both correction bits get exercised here
		test_name = "corner";
		random_operand(op_a);
		send_pair(MOST_NEG, MOST_NEG, 0);
		send_pair(MOST_NEG, MOST_POS, 0);
		send_pair(MOST_POS, MOST_NEG, 0);
		send_pair(MOST_POS, MOST_POS, 0);
		send_pair(MINUS_ONE, MINUS_ONE, 0);
		send_pair(ZERO, op_a, 0);
		send_pair(op_a, ZERO, 0);
		send_pair(PLUS_ONE, MINUS_ONE, 0);
		in_valid = 1'b0;
		drain();

		test_name = "random";
		send_random(N_RANDOM, 1'b1);
		drain();

		test_name = "backpressure";
		bp_mode = 1'b1;
		send_random(N_BP, 1'b1);
		drain();
		bp_mode = 1'b0;
		out_ready = 1'b1;
		repeat (2) next_cycle();

		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d expected products never came out", exp_q.size());
		end
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bw_mul.f
common/bw_mul_pkg.sv
bw_array/bw_pp_row.sv
bw_array/bw_array_stage.sv
design/bw_final_adder.sv
design/bw_mul_top.sv
bench/bw_mul_tb.sv

// File: Makefile
# Verilator build for the Baugh-Wooley multiplier testbench

VERILATOR ?= verilator
TOP       ?= bw_mul_tb
FILELIST  ?= bw_mul.f
BUILD_DIR ?= build
LOG       ?= sim.log

BUILD_FLAGS ?= --binary --timing
LINT_FLAGS  ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
